/* common/corePkg.sv */
// shared by rtl and testbench; machine mode only, no interrupts, mulh and mulhsu not decoded
package corePkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;
  typedef logic [1:0]  csrIdxT;
  typedef logic [3:0]  byteMaskT;

  typedef enum logic [4:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSll,
    aluSrl,
    aluSra,
    aluSlt,
    aluSltu,
    aluMul,
    aluMulhu,
    aluDiv,
    aluDivu,
    aluRem,
    aluRemu,
    aluPassB,
    aluCsrSet
  } aluOpE;

  typedef enum logic [2:0] {typeI, typeU, typeS, typeJ, typeB, typeR, typeSys} instrTypeE;

  // trap picks mtvec on ecall, mepc on mret
  typedef enum logic [1:0] {pcNext, pcBranchJal, pcJalr, pcTrap} pcSelE;

  typedef enum logic [1:0] {wbAlu, wbLoad, wbLink, wbCsr} wbSelE;

  localparam wordT resetVector = 32'h8000_0000;
  localparam wordT ecallCause  = 32'd11;

  localparam logic [11:0] csrMstatus = 12'h300;
  localparam logic [11:0] csrMtvec   = 12'h305;
  localparam logic [11:0] csrMepc    = 12'h341;
  localparam logic [11:0] csrMcause  = 12'h342;

  // csr file slots, unknown addresses fall into mtvec
  localparam csrIdxT slotMcause  = 2'd0;
  localparam csrIdxT slotMepc    = 2'd1;
  localparam csrIdxT slotMstatus = 2'd2;
  localparam csrIdxT slotMtvec   = 2'd3;

  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  localparam wordT instrEcall  = 32'h0000_0073;
  localparam wordT instrEbreak = 32'h0010_0073;
  localparam wordT instrMret   = 32'h3020_0073;

endpackage

/* decode/idu.sv */
// pure decode, no state; unknown opcodes decode as I type and still write rd
`timescale 1ns/1ps

module idu (
  input  corePkg::wordT     instr,
  input  logic              instrValid,
  output corePkg::regAddrT  rs1,
  output corePkg::regAddrT  rs2,
  output corePkg::regAddrT  rd,
  output corePkg::wordT     imm,
  output corePkg::aluOpE    aluOp,
  output logic              src1Pc,
  output logic [1:0]        src2Sel,
  output corePkg::pcSelE    pcSel,
  output corePkg::wbSelE    wbSel,
  output logic [2:0]        branchFunct,
  output logic              dataRen,
  output logic              dataWen,
  output corePkg::byteMaskT storeMask,
  output logic [1:0]        loadSize,
  output logic              loadSigned,
  output logic              regWriteEn,
  output logic              csrWriteEn,
  output corePkg::csrIdxT   csrSel,
  output logic              isEcall,
  output logic              isMret,
  output logic              isEbreak
);
  import corePkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  instrTypeE  instrType;
  wordT       immI, immU, immS, immJ, immB, immSys;
  logic       isCsr;
  logic       writesRd;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    case (opcode)
      opLui, opAuipc: instrType = typeU;
      opJal:          instrType = typeJ;
      opStore:        instrType = typeS;
      opBranch:       instrType = typeB;
      opOp:           instrType = typeR;
      opSystem:       instrType = typeSys;
      default:        instrType = typeI;
    endcase
  end

  assign immI   = {{20{instr[31]}}, instr[31:20]};
  assign immU   = {instr[31:12], 12'b0};
  assign immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immSys = {20'b0, instr[31:20]};

  always_comb begin
    case (instrType)
      typeU:   imm = immU;
      typeS:   imm = immS;
      typeJ:   imm = immJ;
      typeB:   imm = immB;
      typeSys: imm = immSys;
      default: imm = immI;
    endcase
  end

  always_comb begin
    aluOp = aluAdd;
    case (instrType)
      typeU: aluOp = (opcode == opLui) ? aluPassB : aluAdd;
      typeI: begin
        // loads and jalr keep the address add
        if (opcode == opOpImm) begin
          case (funct3)
            3'b001:  aluOp = aluSll;
            3'b010:  aluOp = aluSlt;
            3'b011:  aluOp = aluSltu;
            3'b100:  aluOp = aluXor;
            3'b101:  aluOp = instr[30] ? aluSra : aluSrl;
            3'b110:  aluOp = aluOr;
            3'b111:  aluOp = aluAnd;
            default: aluOp = aluAdd;
          endcase
        end
      end
      typeR: begin
        if (funct7 == 7'b0000001) begin
          case (funct3)
            3'b011:  aluOp = aluMulhu;
            3'b100:  aluOp = aluDiv;
            3'b101:  aluOp = aluDivu;
            3'b110:  aluOp = aluRem;
            3'b111:  aluOp = aluRemu;
            default: aluOp = aluMul;
          endcase
        end else begin
          case (funct3)
            3'b000:  aluOp = instr[30] ? aluSub : aluAdd;
            3'b001:  aluOp = aluSll;
            3'b010:  aluOp = aluSlt;
            3'b011:  aluOp = aluSltu;
            3'b100:  aluOp = aluXor;
            3'b101:  aluOp = instr[30] ? aluSra : aluSrl;
            3'b110:  aluOp = aluOr;
            default: aluOp = aluAnd;
          endcase
        end
      end
      // branches compare, the target adder lives in the core
      typeB: begin
        case (funct3[2:1])
          2'b10:   aluOp = aluSlt;
          2'b11:   aluOp = aluSltu;
          default: aluOp = aluSub;
        endcase
      end
      typeSys: aluOp = (funct3 == 3'b010) ? aluCsrSet : aluPassB;
      default: aluOp = aluAdd;
    endcase
  end

  assign isCsr = (opcode == opSystem) && (funct3 == 3'b001 || funct3 == 3'b010);

  assign src1Pc = (opcode == opAuipc) || (opcode == opJal);

  always_comb begin
    case (opcode)
      opLui, opAuipc, opLoad, opOpImm, opStore, opJalr, opJal: src2Sel = 2'd1;
      // csr ops take rs1 as the second operand
      opSystem: src2Sel = 2'd2;
      default:  src2Sel = 2'd0;
    endcase
  end

  always_comb begin
    if (instr == instrEcall || instr == instrMret) begin
      pcSel = pcTrap;
    end else if (opcode == opBranch || opcode == opJal) begin
      pcSel = pcBranchJal;
    end else if (opcode == opJalr) begin
      pcSel = pcJalr;
    end else begin
      pcSel = pcNext;
    end
  end

  always_comb begin
    case (opcode)
      opLoad:        wbSel = wbLoad;
      opJal, opJalr: wbSel = wbLink;
      opSystem:      wbSel = wbCsr;
      default:       wbSel = wbAlu;
    endcase
  end

  // 3'b010 is not a branch funct3, used as always taken for jal
  assign branchFunct = (instrType == typeB) ? funct3 : 3'b010;

  always_comb begin
    case (funct3[1:0])
      2'b00:   storeMask = 4'b0001;
      2'b01:   storeMask = 4'b0011;
      default: storeMask = 4'b1111;
    endcase
  end

  assign loadSize   = funct3[1:0];
  assign loadSigned = ~funct3[2];

  always_comb begin
    case (instrType)
      typeS, typeB: writesRd = 1'b0;
      typeSys:      writesRd = isCsr;
      default:      writesRd = 1'b1;
    endcase
  end

  always_comb begin
    case (instr[31:20])
      csrMcause:  csrSel = slotMcause;
      csrMepc:    csrSel = slotMepc;
      csrMstatus: csrSel = slotMstatus;
      csrMtvec:   csrSel = slotMtvec;
      default:    csrSel = slotMtvec;
    endcase
  end

  assign dataRen    = instrValid && (opcode == opLoad);
  assign dataWen    = instrValid && (instrType == typeS);
  assign regWriteEn = instrValid && writesRd;
  assign csrWriteEn = instrValid && isCsr;
  assign isEcall    = instrValid && (instr == instrEcall);
  assign isMret     = instrValid && (instr == instrMret);
  assign isEbreak   = instrValid && (instr == instrEbreak);

endmodule

/* verilog/regFile.sv */
// x0 reads zero and ignores writes; reads are combinational
`timescale 1ns/1ps

module regFile (
  input  logic             clock,
  input  logic             arstN,
  input  corePkg::regAddrT rs1,
  input  corePkg::regAddrT rs2,
  input  corePkg::regAddrT rd,
  input  logic             writeEn,
  input  corePkg::wordT    writeData,
  output corePkg::wordT    rdata1,
  output corePkg::wordT    rdata2
);
  import corePkg::*;

  wordT regs [32];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && rd != '0) begin
      regs[rd] <= writeData;
    end
  end

  // regs[0] never leaves reset
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

/* verilog/alu.sv */
// purely combinational, one-cycle multiply and divide; long path, not for high clock rates
`timescale 1ns/1ps

module alu (
  input  corePkg::aluOpE aluOp,
  input  corePkg::wordT  a,
  input  corePkg::wordT  b,
  output corePkg::wordT  result
);
  import corePkg::*;

  logic [4:0]  shamt;
  logic [63:0] productU;
  logic        divByZero;
  logic        divOverflow;

  assign shamt    = b[4:0];
  assign productU = {32'b0, a} * {32'b0, b};
  assign divByZero = (b == '0);
  // most negative over minus one
  assign divOverflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);

  always_comb begin
    case (aluOp)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluSll:   result = a << shamt;
      aluSrl:   result = a >> shamt;
      aluSra:   result = $signed(a) >>> shamt;
      aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
      aluSltu:  result = {31'b0, a < b};
      aluMul:   result = productU[31:0];
      aluMulhu: result = productU[63:32];
      aluDiv: begin
        if (divByZero) begin
          result = '1;
        end else if (divOverflow) begin
          result = a;
        end else begin
          result = $signed(a) / $signed(b);
        end
      end
      aluDivu:  result = divByZero ? '1 : a / b;
      aluRem: begin
        if (divByZero) begin
          result = a;
        end else if (divOverflow) begin
          result = '0;
        end else begin
          result = $signed(a) % $signed(b);
        end
      end
      aluRemu:  result = divByZero ? a : a % b;
      aluPassB: result = b;
      // csrrs sets bits in the old csr value
      aluCsrSet: result = a | b;
      default:  result = a + b;
    endcase
  end

endmodule

/* verilog/csrFile.sv */
// mstatus is plain storage with no field behavior; ecall is the only trap source
`timescale 1ns/1ps

module csrFile (
  input  logic            clock,
  input  logic            arstN,
  input  corePkg::csrIdxT csrSel,
  input  logic            writeEn,
  input  corePkg::wordT   writeData,
  input  logic            isEcall,
  input  corePkg::wordT   pc,
  output corePkg::wordT   readData,
  output corePkg::wordT   mtvec,
  output corePkg::wordT   mepc
);
  import corePkg::*;

  wordT csrs [4];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 4; i++) begin
        csrs[i] <= '0;
      end
    end else if (isEcall) begin
      // trap entry, both in one edge
      csrs[slotMepc]   <= pc;
      csrs[slotMcause] <= ecallCause;
    end else if (writeEn) begin
      csrs[csrSel] <= writeData;
    end
  end

  assign readData = csrs[csrSel];
  assign mtvec    = csrs[slotMtvec];
  assign mepc     = csrs[slotMepc];

endmodule

/* verilog/cpuCore.sv */
// single cycle, memories must answer reads in the same cycle; halt clears only on reset
`timescale 1ns/1ps

module cpuCore (
  input  logic              clock,
  input  logic              arstN,
  output corePkg::wordT     pc,
  input  corePkg::wordT     instr,
  input  logic              instrValid,
  output corePkg::wordT     dataAddr,
  output corePkg::wordT     dataWdata,
  output corePkg::byteMaskT dataWmask,
  output logic              dataWen,
  input  corePkg::wordT     dataRdata,
  output logic              dataRen,
  output logic              halted
);
  import corePkg::*;

  logic       retire;
  regAddrT    rs1, rs2, rd;
  wordT       imm, rdata1, rdata2, opA, opB, aluResult;
  wordT       csrRead, mtvec, mepc, laneData, loadData, wbData;
  wordT       pcPlus4, branchTarget, nextPc;
  aluOpE      aluOp;
  logic       src1Pc;
  logic [1:0] src2Sel;
  pcSelE      pcSel;
  wbSelE      wbSel;
  logic [2:0] branchFunct;
  byteMaskT   storeMask;
  logic [1:0] loadSize;
  logic       loadSigned, regWriteEn, csrWriteEn;
  csrIdxT     csrSel;
  logic       isEcall, isMret, isEbreak, branchTaken;
  logic [4:0] laneShift;

  // halt looks like a missing instruction to the decoder
  assign retire = instrValid & ~halted;

  idu idu0 (
    .instr(instr), .instrValid(retire), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .aluOp(aluOp), .src1Pc(src1Pc), .src2Sel(src2Sel), .pcSel(pcSel), .wbSel(wbSel),
    .branchFunct(branchFunct), .dataRen(dataRen), .dataWen(dataWen),
    .storeMask(storeMask), .loadSize(loadSize), .loadSigned(loadSigned),
    .regWriteEn(regWriteEn), .csrWriteEn(csrWriteEn), .csrSel(csrSel),
    .isEcall(isEcall), .isMret(isMret), .isEbreak(isEbreak)
  );

  regFile regFile0 (
    .clock(clock), .arstN(arstN), .rs1(rs1), .rs2(rs2), .rd(rd), .writeEn(regWriteEn),
    .writeData(wbData), .rdata1(rdata1), .rdata2(rdata2)
  );

  csrFile csrFile0 (
    .clock(clock), .arstN(arstN), .csrSel(csrSel), .writeEn(csrWriteEn),
    .writeData(aluResult), .isEcall(isEcall), .pc(pc), .readData(csrRead),
    .mtvec(mtvec), .mepc(mepc)
  );

  // csr ops put the old csr value on operand a
  assign opA = src1Pc ? pc : ((wbSel == wbCsr) ? csrRead : rdata1);
  assign opB = (src2Sel == 2'd1) ? imm : ((src2Sel == 2'd2) ? rdata1 : rdata2);

  alu alu0 (.aluOp(aluOp), .a(opA), .b(opB), .result(aluResult));

  assign dataAddr  = aluResult;
  assign laneShift = {dataAddr[1:0], 3'b000};
  assign dataWdata = rdata2 << laneShift;
  assign dataWmask = storeMask << dataAddr[1:0];
  assign laneData  = dataRdata >> laneShift;

  always_comb begin
    case (loadSize)
      2'd0:    loadData = {{24{loadSigned & laneData[7]}}, laneData[7:0]};
      2'd1:    loadData = {{16{loadSigned & laneData[15]}}, laneData[15:0]};
      default: loadData = laneData;
    endcase
  end

  always_comb begin
    case (wbSel)
      wbLoad:  wbData = loadData;
      wbLink:  wbData = pcPlus4;
      wbCsr:   wbData = csrRead;
      default: wbData = aluResult;
    endcase
  end

  // compare result from sub, slt or sltu
  always_comb begin
    case (branchFunct)
      3'b000:         branchTaken = (aluResult == '0);
      3'b001:         branchTaken = (aluResult != '0);
      3'b100, 3'b110: branchTaken = aluResult[0];
      3'b101, 3'b111: branchTaken = ~aluResult[0];
      default:        branchTaken = 1'b1;
    endcase
  end

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pc + imm;

  always_comb begin
    case (pcSel)
      pcBranchJal: nextPc = branchTaken ? branchTarget : pcPlus4;
      pcJalr:      nextPc = {aluResult[31:1], 1'b0};
      pcTrap:      nextPc = isMret ? mepc : mtvec;
      default:     nextPc = pcPlus4;
    endcase
  end

  // ebreak parks pc on itself
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pc     <= resetVector;
      halted <= 1'b0;
    end else if (retire) begin
      if (isEbreak) begin
        halted <= 1'b1;
      end else begin
        pc <= nextPc;
      end
    end
  end

endmodule

/* testbench/tbMemory.sv */
// 4 KiB shared code and data array at resetVector; address bits above 11 are ignored
`timescale 1ns/1ps

module tbMemory (
  input  logic              clock,
  input  corePkg::wordT     pc,
  output corePkg::wordT     instr,
  input  corePkg::wordT     dataAddr,
  input  corePkg::wordT     dataWdata,
  input  corePkg::byteMaskT dataWmask,
  input  logic              dataWen,
  output corePkg::wordT     dataRdata
);
  import corePkg::*;

  wordT mem [1024];

  assign instr     = mem[pc[11:2]];
  assign dataRdata = mem[dataAddr[11:2]];

  // byte lanes follow the mask
  always @(posedge clock) begin
    if (dataWen) begin
      for (int b = 0; b < 4; b++) begin
        if (dataWmask[b]) begin
          mem[dataAddr[11:2]][8*b +: 8] <= dataWdata[8*b +: 8];
        end
      end
    end
  end

  // pattern differs for every word index
  task automatic fill();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0003);
    end
  endtask

endmodule

/* testbench/coreTb.sv */
// code starts at resetVector; results go to a data window at resetVector + 0x800
`timescale 1ns/1ps

module coreTb;
  import corePkg::*;

  localparam regAddrT x0 = 5'd0;
  localparam regAddrT x1 = 5'd1;
  localparam regAddrT x2 = 5'd2;
  localparam regAddrT x3 = 5'd3;
  localparam regAddrT x5 = 5'd5;
  localparam regAddrT x6 = 5'd6;
  localparam regAddrT x7 = 5'd7;
  localparam regAddrT xBase = 5'd31;

  logic        clock, arstN, instrValid, dataWen, dataRen, halted, stall;
  wordT        pc, instr, dataAddr, dataWdata, dataRdata;
  byteMaskT    dataWmask;
  integer      seed;
  int          emitIdx;
  logic [11:0] nextOff;
  logic [11:0] expOff[$];
  wordT        expVal[$];

  cpuCore dut0 (
    .clock(clock), .arstN(arstN), .pc(pc), .instr(instr), .instrValid(instrValid),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWmask(dataWmask), .dataWen(dataWen),
    .dataRdata(dataRdata), .dataRen(dataRen), .halted(halted)
  );

  tbMemory mem0 (
    .clock(clock), .pc(pc), .instr(instr), .dataAddr(dataAddr), .dataWdata(dataWdata),
    .dataWmask(dataWmask), .dataWen(dataWen), .dataRdata(dataRdata)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic wordT rType(logic [6:0] f7, regAddrT rs2, regAddrT rs1, logic [2:0] f3,
                                 regAddrT rd);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic wordT iType(logic [11:0] imm, regAddrT rs1, logic [2:0] f3, regAddrT rd,
                                 logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic wordT sType(logic [11:0] imm, regAddrT rs2, regAddrT rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
  endfunction

  function automatic wordT bType(logic [12:0] imm, regAddrT rs2, regAddrT rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic wordT jType(logic [20:0] imm, regAddrT rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  function automatic logic branchRule(logic [2:0] f3, wordT a, wordT b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // signed division rules including zero divisor and overflow
  function automatic wordT sDiv(wordT a, wordT b);
    if (b == 32'd0) return 32'hffff_ffff;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
    return $signed(a) / $signed(b);
  endfunction

  function automatic wordT sRem(wordT a, wordT b);
    if (b == 32'd0) return a;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'd0;
    return $signed(a) % $signed(b);
  endfunction

  function automatic wordT pcNow();
    return resetVector + 32'(emitIdx * 4);
  endfunction

  function automatic wordT memWord(logic [11:0] off);
    return mem0.mem[10'd512 + 10'(off >> 2)];
  endfunction

  task automatic checkWord(string name, wordT exp, wordT act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic checkFlag(string name, bit exp, bit act);
    if (act !== exp) begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic emit(wordT w);
    mem0.mem[emitIdx] = w;
    emitIdx++;
  endtask

  task automatic loadImm(regAddrT rd, wordT v);
    wordT hi;
    hi = v + 32'h800;
    emit({hi[31:12], rd, opLui});
    emit(iType(v[11:0], rd, 3'b000, rd, opOpImm));
  endtask

  task automatic expectAt(logic [11:0] off, wordT v);
    expOff.push_back(off);
    expVal.push_back(v);
  endtask

  task automatic storeResult(regAddrT rs, wordT exp);
    emit(sType(nextOff, rs, xBase, 3'b010));
    expectAt(nextOff, exp);
    nextOff += 12'd4;
  endtask

  // x3 = x1 op x2 and its store
  task automatic rOp(logic [6:0] f7, logic [2:0] f3, wordT exp);
    emit(rType(f7, x2, x1, f3, x3));
    storeResult(x3, exp);
  endtask

  task automatic startTest();
    mem0.fill();
    emitIdx = 0;
    nextOff = 12'd0;
    expOff.delete();
    expVal.delete();
    loadImm(xBase, resetVector + 32'h800);
  endtask

  task automatic runProgram(string name);
    wordT r;
    wordT heldPc;
    logic wasValid;
    @(posedge clock);
    instrValid <= 1'b0;
    arstN <= 1'b0;
    repeat (5) @(posedge clock);
    arstN <= 1'b1;
    @(negedge clock);
    checkWord($sformatf("%s reset pc", name), resetVector, pc);
    checkFlag($sformatf("%s reset halted", name), 1'b0, halted);
    heldPc = pc;
    wasValid = 1'b0;
    for (int cycles = 0; cycles < 3000; cycles++) begin
      @(posedge clock);
      r = $random(seed);
      instrValid <= stall ? (r[2:0] > 3'd2) : 1'b1;
      @(negedge clock);
      // no retire on the edge just passed
      if (!wasValid) begin
        checkWord($sformatf("%s stalled pc", name), heldPc, pc);
      end
      checkFlag($sformatf("%s dataRen", name), instrValid && (instr[6:0] == opLoad),
                dataRen);
      checkFlag($sformatf("%s dataWen", name), instrValid && (instr[6:0] == opStore),
                dataWen);
      if (halted) break;
      heldPc = pc;
      wasValid = instrValid;
    end
    if (!halted) begin
      $display("core did not halt within 3000 cycles in test %s", name);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
    for (int i = 0; i < expOff.size(); i++) begin
      checkWord($sformatf("%s[%0d]", name, i), expVal[i], memWord(expOff[i]));
    end
  endtask

  task automatic testIntOps();
    wordT a, b, r, at;
    logic [19:0] u20;
    a = $random(seed);
    b = $random(seed);
    r = $random(seed);
    u20 = r[31:12];
    startTest();
    loadImm(x1, a);
    loadImm(x2, b);
    rOp(7'h00, 3'b000, a + b);
    rOp(7'h20, 3'b000, a - b);
    rOp(7'h00, 3'b001, a << b[4:0]);
    rOp(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
    rOp(7'h00, 3'b011, {31'b0, a < b});
    rOp(7'h00, 3'b100, a ^ b);
    rOp(7'h00, 3'b101, a >> b[4:0]);
    rOp(7'h20, 3'b101, $signed(a) >>> b[4:0]);
    rOp(7'h00, 3'b110, a | b);
    rOp(7'h00, 3'b111, a & b);
    emit(iType(r[11:0], x1, 3'b000, x3, opOpImm));
    storeResult(x3, a + {{20{r[11]}}, r[11:0]});
    emit({u20, x3, opLui});
    storeResult(x3, {u20, 12'b0});
    at = pcNow();
    emit({u20, x3, opAuipc});
    storeResult(x3, at + {u20, 12'b0});
    emit(instrEbreak);
    runProgram("intOps");
  endtask

  task automatic testLoadStore();
    wordT w, v;
    logic [11:0] off;
    w = $random(seed);
    v = $random(seed);
    // negative upper byte and halfword and bit 15 set for the unsigned loads
    w = w | 32'h8000_8000;
    startTest();
    loadImm(x1, w);
    loadImm(x2, v);
    off = nextOff;
    nextOff += 12'd8;
    emit(sType(off, x2, xBase, 3'b010));
    emit(sType(off + 12'd1, x1, xBase, 3'b000));
    expectAt(off, {v[31:16], w[7:0], v[7:0]});
    emit(sType(off + 12'd4, x2, xBase, 3'b010));
    emit(sType(off + 12'd6, x1, xBase, 3'b001));
    expectAt(off + 12'd4, {w[15:0], v[15:0]});
    off = nextOff;
    nextOff += 12'd4;
    emit(sType(off, x1, xBase, 3'b010));
    expectAt(off, w);
    emit(iType(off + 12'd3, xBase, 3'b000, x3, opLoad));
    storeResult(x3, {{24{w[31]}}, w[31:24]});
    emit(iType(off + 12'd1, xBase, 3'b000, x3, opLoad));
    storeResult(x3, {{24{w[15]}}, w[15:8]});
    emit(iType(off + 12'd1, xBase, 3'b100, x3, opLoad));
    storeResult(x3, {24'b0, w[15:8]});
    emit(iType(off + 12'd2, xBase, 3'b001, x3, opLoad));
    storeResult(x3, {{16{w[31]}}, w[31:16]});
    emit(iType(off, xBase, 3'b101, x3, opLoad));
    storeResult(x3, {16'b0, w[15:0]});
    emit(iType(off, xBase, 3'b010, x3, opLoad));
    storeResult(x3, w);
    emit(instrEbreak);
    runProgram("loadStore");
  endtask

  task automatic testBranches();
    wordT pa[3];
    wordT pb[3];
    logic [2:0] fs[6];
    wordT at;
    pa = '{32'hffff_fffb, 32'd7, 32'd7};
    pb = '{32'd3, 32'd7, 32'hffff_fffb};
    fs = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    startTest();
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        loadImm(x1, pa[j]);
        loadImm(x2, pb[j]);
        emit(bType(13'd12, x2, x1, fs[i]));
        emit(iType(12'd1, x0, 3'b000, x3, opOpImm));
        emit(jType(21'd8, x0));
        // only reached when taken
        emit(iType(12'd2, x0, 3'b000, x3, opOpImm));
        storeResult(x3, branchRule(fs[i], pa[j], pb[j]) ? 32'd2 : 32'd1);
      end
    end
    at = pcNow();
    emit(jType(21'd8, x5));
    emit(instrEbreak);
    storeResult(x5, at + 32'd4);
    at = pcNow();
    emit({20'h0, x6, opAuipc});
    emit(iType(12'd12, x6, 3'b000, x7, opJalr));
    emit(instrEbreak);
    storeResult(x7, at + 32'd8);
    emit(instrEbreak);
    runProgram("branches");
  endtask

  task automatic testMulDiv();
    wordT a, b;
    logic [63:0] p;
    a = $random(seed);
    b = $random(seed);
    p = {32'b0, a} * {32'b0, b};
    startTest();
    loadImm(x1, a);
    loadImm(x2, b);
    rOp(7'h01, 3'b000, p[31:0]);
    rOp(7'h01, 3'b011, p[63:32]);
    rOp(7'h01, 3'b100, sDiv(a, b));
    rOp(7'h01, 3'b101, a / b);
    rOp(7'h01, 3'b110, sRem(a, b));
    rOp(7'h01, 3'b111, a % b);
    loadImm(x2, 32'd0);
    rOp(7'h01, 3'b100, sDiv(a, 32'd0));
    rOp(7'h01, 3'b101, 32'hffff_ffff);
    rOp(7'h01, 3'b110, sRem(a, 32'd0));
    rOp(7'h01, 3'b111, a);
    emit(instrEbreak);
    runProgram("mulDiv");
  endtask

  task automatic testCsrTrap();
    wordT hAddr, e;
    hAddr = resetVector + 32'h400;
    startTest();
    loadImm(x1, hAddr);
    emit(iType(csrMtvec, x1, 3'b001, x2, opSystem));
    storeResult(x2, 32'd0);
    emit(iType(csrMtvec, x0, 3'b010, x3, opSystem));
    storeResult(x3, hAddr);
    e = pcNow();
    emit(instrEcall);
    emit(iType(12'h055, x0, 3'b000, x7, opOpImm));
    storeResult(x7, 32'h55);
    emit(instrEbreak);
    // handler returns past the ecall
    emitIdx = 256;
    emit(iType(csrMcause, x0, 3'b010, x5, opSystem));
    storeResult(x5, ecallCause);
    emit(iType(csrMepc, x0, 3'b010, x6, opSystem));
    storeResult(x6, e);
    emit(iType(12'd4, x6, 3'b000, x6, opOpImm));
    emit(iType(csrMepc, x6, 3'b001, x0, opSystem));
    emit(instrMret);
    runProgram("csrTrap");
  endtask

  task automatic testHaltStall();
    wordT a, b, eb, keep;
    logic [11:0] off;
    a = $random(seed);
    b = $random(seed);
    startTest();
    loadImm(x1, a);
    loadImm(x2, b);
    rOp(7'h00, 3'b000, a + b);
    rOp(7'h00, 3'b100, a ^ b);
    rOp(7'h01, 3'b000, a * b);
    off = nextOff;
    keep = memWord(off);
    eb = pcNow();
    emit(instrEbreak);
    emit(sType(off, x1, xBase, 3'b010));
    stall = 1'b1;
    runProgram("haltStall");
    stall = 1'b0;
    repeat (20) begin
      @(posedge clock);
      instrValid <= 1'b1;
    end
    @(negedge clock);
    checkFlag("haltStall halted", 1'b1, halted);
    checkWord("haltStall pc", eb, pc);
    checkWord("haltStall store after ebreak", keep, memWord(off));
    for (int i = 0; i < expOff.size(); i++) begin
      checkWord($sformatf("haltStall late[%0d]", i), expVal[i], memWord(expOff[i]));
    end
  endtask

  initial begin
    seed = 32'hcd6;
    arstN = 1'b0;
    instrValid = 1'b0;
    stall = 1'b0;
    testIntOps();
    testLoadStore();
    testBranches();
    testMulDiv();
    testCsrTrap();
    testHaltStall();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* list.f */
common/corePkg.sv
decode/idu.sv
verilog/regFile.sv
verilog/alu.sv
verilog/csrFile.sv
verilog/cpuCore.sv
testbench/tbMemory.sv
testbench/coreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
